/* hw/mul_arith_pkg.sv */
package mul_arith_pkg;

    localparam int op_w   = 16;
    localparam int prod_w = 2 * op_w;

    // one gated copy of operand b per bit of operand a
    localparam int pp_rows = op_w;

    // Dadda target heights, one entry per reduction stage
    // the last entry leaves two rows for the prefix adder
    localparam int dadda_heights [6] = '{13, 9, 6, 4, 3, 2};

    typedef logic [op_w-1:0]   operand_t;
    typedef logic [prod_w-1:0] product_t;

    // sum and carry rows out of the column reduction
    typedef logic [prod_w-1:0] reduce_row_t;

endpackage

/* hw/mul_regmap_pkg.sv */
package mul_regmap_pkg;

    localparam int apb_addr_w = 8;

    // byte offsets on the APB side
    localparam logic [apb_addr_w-1:0] reg_op_a    = 8'h00;
    localparam logic [apb_addr_w-1:0] reg_op_b    = 8'h04;
    localparam logic [apb_addr_w-1:0] reg_ctrl    = 8'h08;
    localparam logic [apb_addr_w-1:0] reg_status  = 8'h0C;
    localparam logic [apb_addr_w-1:0] reg_product = 8'h10;

    localparam int ctrl_start_bit = 0;   // write 1 to launch

    localparam int status_done_bit = 0;  // sticky until next start
    localparam int status_busy_bit = 1;

endpackage

/* hw/mul_core_if.sv */
`timescale 1ns/1ps

interface mul_core_if;
    import mul_arith_pkg::*;

    operand_t op_a;
    operand_t op_b;
    logic     start;    // one cycle per request
    product_t product;
    logic     valid;    // one cycle, two after start

    modport regs (
        output op_a,
        output op_b,
        output start,
        input  product,
        input  valid
    );

    modport core (
        input  op_a,
        input  op_b,
        input  start,
        output product,
        output valid
    );

endinterface

/* hw/mul_regs.sv */
`timescale 1ns/1ps

module mul_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [mul_regmap_pkg::apb_addr_w-1:0] paddr,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    mul_core_if.regs                            core
);
    import mul_arith_pkg::*;
    import mul_regmap_pkg::*;

    operand_t    op_a_q;
    operand_t    op_b_q;
    product_t    product_q;
    logic        start_q;
    logic        done;
    logic        busy;
    logic [1:0]  inflight;    // starts not yet answered by valid
    logic        setup;
    logic        wr_en;
    logic        start_wr;
    logic        addr_ok;
    logic [31:0] rd_word;

    assign setup    = psel && !penable;
    assign wr_en    = psel && penable && pwrite;
    assign start_wr = wr_en && (paddr == reg_ctrl) && pwdata[ctrl_start_bit];
    assign busy     = (inflight != 2'd0);

    assign pready = 1'b1;   // no wait states

    assign core.op_a  = op_a_q;
    assign core.op_b  = op_b_q;
    assign core.start = start_q;

    always_comb begin
        addr_ok = 1'b1;
        rd_word = '0;
        case (paddr)
            reg_op_a:    rd_word = {{(32 - op_w){1'b0}}, op_a_q};
            reg_op_b:    rd_word = {{(32 - op_w){1'b0}}, op_b_q};
            reg_ctrl:    rd_word = '0;          // start bit self-clears
            reg_status: begin
                rd_word[status_done_bit] = done;
                rd_word[status_busy_bit] = busy;
            end
            reg_product: rd_word = product_q;
            default:     addr_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_a_q    <= '0;
            op_b_q    <= '0;
            product_q <= '0;
            start_q   <= 1'b0;
            done      <= 1'b0;
            inflight  <= 2'd0;
            prdata    <= '0;
            pslverr   <= 1'b0;
        end else begin
            if (wr_en && paddr == reg_op_a) begin
                op_a_q <= pwdata[op_w-1:0];
            end
            if (wr_en && paddr == reg_op_b) begin
                op_b_q <= pwdata[op_w-1:0];
            end

            start_q <= start_wr;

            // done only for the newest request
            if (start_wr) begin
                done <= 1'b0;
            end else if (core.valid && inflight == 2'd1) begin
                done <= 1'b1;
            end

            if (core.valid) begin
                product_q <= core.product;
            end

            if (start_wr && !core.valid) begin
                inflight <= inflight + 2'd1;
            end else if (!start_wr && core.valid) begin
                inflight <= inflight - 2'd1;
            end

            // read data and error are ready for the access phase
            if (setup && !pwrite) begin
                prdata <= rd_word;
            end
            pslverr <= setup && !addr_ok;
        end
    end

endmodule

/* hw/dadda_reduce.sv */
`timescale 1ns/1ps

module dadda_reduce (
    input  mul_arith_pkg::operand_t    op_a,
    input  mul_arith_pkg::operand_t    op_b,
    output mul_arith_pkg::reduce_row_t row_sum,
    output mul_arith_pkg::reduce_row_t row_carry
);
    import mul_arith_pkg::*;

    localparam int n_stages = $size(dadda_heights);

    localparam int k_fa     = 0;
    localparam int k_ha     = 1;
    localparam int k_height = 2;

    // replays the Dadda schedule up to one column of one stage
    function automatic int sched(int stage, int col, int kind);
        int h [prod_w];
        int cin;
        int excess;
        int nfa;
        int nha;
        int res;
        res = 0;
        for (int c = 0; c < prod_w; c++) begin
            h[c] = (c < op_w) ? c + 1 : 2 * op_w - 1 - c;
        end
        for (int s = 0; s <= stage; s++) begin
            cin = 0;
            for (int c = 0; c < prod_w; c++) begin
                excess = h[c] + cin - dadda_heights[s];
                nfa    = (excess > 0) ? excess / 2 : 0;
                nha    = (excess > 0) ? excess % 2 : 0;
                if (s == stage && c == col) begin
                    res = (kind == k_fa) ? nfa : (kind == k_ha) ? nha : h[c];
                end
                h[c] = h[c] - 2 * nfa - nha + cin;  // height entering next stage
                cin  = nfa + nha;
            end
        end
        return res;
    endfunction

    logic [pp_rows-1:0] col_bits [0:n_stages][0:prod_w-1];
    logic [pp_rows-1:0] cell_sum [0:n_stages-1][0:prod_w-1];
    logic [pp_rows-1:0] cell_cy  [0:n_stages-1][0:prod_w-1];

    // partial products sorted into weight columns
    for (genvar c = 0; c < prod_w; c++) begin : g_pp_col
        localparam int lo = (c < op_w) ? 0 : c - op_w + 1;
        localparam int h0 = sched(0, c, k_height);
        for (genvar r = 0; r < pp_rows; r++) begin : g_pp_row
            if (r < h0) begin : g_and
                assign col_bits[0][c][r] = op_a[lo + r] & op_b[c - lo - r];
            end else begin : g_zero
                assign col_bits[0][c][r] = 1'b0;
            end
        end
    end

    for (genvar s = 0; s < n_stages; s++) begin : g_stage
        for (genvar c = 0; c < prod_w; c++) begin : g_col
            localparam int h     = sched(s, c, k_height);
            localparam int nfa   = sched(s, c, k_fa);
            localparam int nha   = sched(s, c, k_ha);
            localparam int ncell = nfa + nha;
            localparam int used  = 3 * nfa + 2 * nha;
            localparam int npass = h - used;
            localparam int ncin  = sched(s, c - 1, k_fa) + sched(s, c - 1, k_ha);

            for (genvar k = 0; k < pp_rows; k++) begin : g_cell
                if (k < nfa) begin : g_fa
                    logic x;
                    logic y;
                    logic z;
                    assign x = col_bits[s][c][3 * k];
                    assign y = col_bits[s][c][3 * k + 1];
                    assign z = col_bits[s][c][3 * k + 2];
                    assign cell_sum[s][c][k] = x ^ y ^ z;
                    assign cell_cy[s][c][k]  = (x & y) | (x & z) | (y & z);
                end else if (k < ncell) begin : g_ha
                    localparam int b = 3 * nfa + 2 * (k - nfa);
                    assign cell_sum[s][c][k] = col_bits[s][c][b] ^ col_bits[s][c][b + 1];
                    assign cell_cy[s][c][k]  = col_bits[s][c][b] & col_bits[s][c][b + 1];
                end else begin : g_idle
                    assign cell_sum[s][c][k] = 1'b0;
                    assign cell_cy[s][c][k]  = 1'b0;
                end
            end

            // sums, untouched bits, then carries from the column below
            for (genvar r = 0; r < pp_rows; r++) begin : g_next
                if (r < ncell) begin : g_sum
                    assign col_bits[s + 1][c][r] = cell_sum[s][c][r];
                end else if (r < ncell + npass) begin : g_keep
                    assign col_bits[s + 1][c][r] = col_bits[s][c][used + r - ncell];
                end else if (r < ncell + npass + ncin) begin : g_carry
                    assign col_bits[s + 1][c][r] = cell_cy[s][c - 1][r - ncell - npass];
                end else begin : g_empty
                    assign col_bits[s + 1][c][r] = 1'b0;
                end
            end
        end
    end

    for (genvar c = 0; c < prod_w; c++) begin : g_out
        assign row_sum[c]   = col_bits[n_stages][c][0];
        assign row_carry[c] = col_bits[n_stages][c][1];
    end

endmodule

/* hw/kogge_stone_adder.sv */
`timescale 1ns/1ps

module kogge_stone_adder #(
    parameter int width = 32
) (
    input  logic [width-1:0] in_a,
    input  logic [width-1:0] in_b,
    input  logic             cin,
    output logic [width-1:0] sum,
    output logic             cout
);
    localparam int levels = $clog2(width);

    logic [width-1:0] p;
    logic [width-1:0] g     [0:levels];
    logic [width-1:0] p_grp [0:levels];

    assign p        = in_a ^ in_b;
    assign p_grp[0] = p;

    // carry in folded into bit 0 generate
    for (genvar i = 0; i < width; i++) begin : g_init
        if (i == 0) begin : g_lsb
            assign g[0][i] = (in_a[i] & in_b[i]) | (p[i] & cin);
        end else begin : g_bit
            assign g[0][i] = in_a[i] & in_b[i];
        end
    end

    for (genvar l = 0; l < levels; l++) begin : g_level
        localparam int d = 1 << l;
        for (genvar i = 0; i < width; i++) begin : g_node
            if (i >= 2 * d) begin : g_black
                assign g[l + 1][i]     = g[l][i] | (p_grp[l][i] & g[l][i - d]);
                assign p_grp[l + 1][i] = p_grp[l][i] & p_grp[l][i - d];
            end else if (i >= d) begin : g_gray
                assign g[l + 1][i]     = g[l][i] | (p_grp[l][i] & g[l][i - d]);
                assign p_grp[l + 1][i] = p_grp[l][i];   // prefix reaches bit 0
            end else begin : g_pass
                assign g[l + 1][i]     = g[l][i];
                assign p_grp[l + 1][i] = p_grp[l][i];
            end
        end
    end

    assign sum  = p ^ {g[levels][width-2:0], cin};
    assign cout = g[levels][width-1];

endmodule

/* hw/mul_core.sv */
`timescale 1ns/1ps

module mul_core (
    input logic      clk,
    input logic      rst_n,
    mul_core_if.core core
);
    import mul_arith_pkg::*;

    reduce_row_t red_sum;
    reduce_row_t red_carry;
    reduce_row_t s1_sum;     // stage one rows
    reduce_row_t s1_carry;
    product_t    add_sum;
    product_t    prod_q;     // stage two result
    logic [1:0]  vld_pipe;

    dadda_reduce u_reduce (
        .op_a      (core.op_a),
        .op_b      (core.op_b),
        .row_sum   (red_sum),
        .row_carry (red_carry)
    );

    kogge_stone_adder #(
        .width (prod_w)
    ) u_adder (
        .in_a (s1_sum),
        .in_b (s1_carry),
        .cin  (1'b0),
        .sum  (add_sum),
        .cout ()            // product always fits
    );

    always_ff @(posedge clk) begin
        if (core.start) begin
            s1_sum   <= red_sum;
            s1_carry <= red_carry;
        end
        if (vld_pipe[0]) begin
            prod_q <= add_sum;
        end
    end

    // one bit per stage, follows each start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_pipe <= 2'b00;
        end else begin
            vld_pipe <= {vld_pipe[0], core.start};
        end
    end

    assign core.product = prod_q;
    assign core.valid   = vld_pipe[1];

endmodule

/* hw/mul_apb_top.sv */
`timescale 1ns/1ps

module mul_apb_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [mul_regmap_pkg::apb_addr_w-1:0] paddr,
    input  logic [31:0]                           pwdata,
    output logic [31:0]                           prdata,
    output logic                                  pready,
    output logic                                  pslverr
);

    mul_core_if u_core_if ();

    mul_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .core    (u_core_if)
    );

    mul_core u_core (
        .clk   (clk),
        .rst_n (rst_n),
        .core  (u_core_if)
    );

endmodule

/* include/tb_mul_tasks.svh */
`ifndef TB_MUL_TASKS_SVH
`define TB_MUL_TASKS_SVH

task automatic report_failure(input string what);
    n_other_err++;
    $display("error at time %0t: %s", $time, what);
endtask

task automatic check_product(input string name, input product_t got, input product_t exp);
    n_checks++;
    if (got !== exp) begin
        n_product_err++;
        $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
        n_word_err++;
        $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_err(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
        n_pslverr_err++;
        $display("mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

// setup then access, called and left 5 ns after a rising edge
task automatic apb_access(input logic wr, input logic [apb_addr_w-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #drive_delay;
    penable = 1'b1;
    rdata   = prdata;   // both registered on the setup edge
    err     = pslverr;
    if (pready !== 1'b1) begin
        report_failure("pready is not high in the access phase");
    end
    @(posedge clk);
    #drive_delay;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic write_reg(input logic [apb_addr_w-1:0] addr, input logic [31:0] data);
    logic [31:0] rd_unused;
    logic        err;
    apb_access(1'b1, addr, data, rd_unused, err);
    check_err($sformatf("pslverr on write 0x%02h", addr), err, 1'b0);
endtask

task automatic read_reg(input logic [apb_addr_w-1:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_err($sformatf("pslverr on read 0x%02h", addr), err, 1'b0);
endtask

function automatic product_t exact_product(input operand_t a, input operand_t b);
    return product_t'(a) * product_t'(b);
endfunction

task automatic wait_done();
    logic [31:0] status;
    int          polls;
    status = '0;
    polls  = 0;
    while (!status[status_done_bit] && polls < max_polls) begin
        read_reg(reg_status, status);
        polls++;
    end
    if (!status[status_done_bit]) begin
        report_failure("done bit never set after start");
    end
endtask

task automatic run_multiply(input operand_t a, input operand_t b);
    logic [31:0] rd;
    write_reg(reg_op_a, 32'(a));
    write_reg(reg_op_b, 32'(b));
    write_reg(reg_ctrl, start_word);
    wait_done();
    read_reg(reg_product, rd);
    check_product($sformatf("product %h*%h", a, b), rd, exact_product(a, b));
endtask

`endif

/* testbench/tb_mul_apb.sv */
`timescale 1ns/1ps

module tb_mul_apb;
    import mul_arith_pkg::*;
    import mul_regmap_pkg::*;

    localparam int clk_period  = 100;
    localparam int drive_delay = 5;
    localparam int n_random    = 200;
    localparam int max_polls   = 8;
    localparam int test_cycles = (n_random + 40) * 20;   // about 14 cycles per multiply
    localparam int margin      = 500;

    localparam logic [31:0] start_word = 32'd1 << ctrl_start_bit;
    localparam logic [31:0] done_word  = 32'd1 << status_done_bit;
    localparam logic [31:0] busy_word  = 32'd1 << status_busy_bit;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;

    int n_checks;
    int n_product_err;
    int n_word_err;
    int n_pslverr_err;
    int n_other_err;

    mul_apb_top u_mul_apb_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    `include "tb_mul_tasks.svh"

    task automatic reset_readback();
        logic [31:0] rd;
        for (int i = 0; i <= 4; i++) begin
            read_reg(apb_addr_w'(4 * i), rd);
            check_word($sformatf("reset value of 0x%02h", 4 * i), rd, 32'h0);
        end
    endtask

    task automatic corner_products();
        run_multiply(16'h0000, 16'h1234);
        run_multiply(16'h0001, 16'hFFFF);
        run_multiply(16'hFFFF, 16'hFFFF);
        run_multiply(16'h8000, 16'h8000);
        run_multiply(16'hAAAA, 16'h5555);
    endtask

    task automatic random_products();
        logic [31:0] rnd;
        for (int i = 0; i < n_random; i++) begin
            rnd = $urandom();
            run_multiply(rnd[15:0], rnd[31:16]);
        end
    endtask

    task automatic status_flags();
        logic [31:0] rd;
        run_multiply(16'h0003, 16'h0007);
        read_reg(reg_status, rd);
        check_word("status after done", rd, done_word);
        write_reg(reg_ctrl, start_word);
        read_reg(reg_status, rd);   // done cleared, one in flight
        check_word("status right after start", rd, busy_word);
        wait_done();
        write_reg(reg_ctrl, start_word);
        repeat (3) @(posedge clk);
        #drive_delay;
        read_reg(reg_status, rd);   // setup edge four cycles after the start write
        check_word("status four cycles after start", rd, done_word);
        read_reg(reg_product, rd);
        check_product("product after restart", rd, exact_product(16'h0003, 16'h0007));
    endtask

    task automatic bus_errors();
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, 8'h14, '0, rd, err);
        check_err("pslverr on read 0x14", err, 1'b1);
        apb_access(1'b1, 8'h40, 32'h1234, rd, err);
        check_err("pslverr on write 0x40", err, 1'b1);
        apb_access(1'b0, 8'h02, '0, rd, err);
        check_err("pslverr on read 0x02", err, 1'b1);
        run_multiply(16'h1234, 16'h0010);
        write_reg(reg_product, 32'hDEADBEEF);
        write_reg(reg_status, 32'h3);
        read_reg(reg_product, rd);
        check_product("product after bus write", rd, exact_product(16'h1234, 16'h0010));
        read_reg(reg_status, rd);
        check_word("status after bus write", rd, done_word);
    endtask

    task automatic back_to_back_starts();
        logic [31:0] rd;
        write_reg(reg_op_a, 32'h1111);
        write_reg(reg_op_b, 32'h2222);
        write_reg(reg_ctrl, start_word);
        write_reg(reg_ctrl, start_word);
        read_reg(reg_status, rd);   // two requests in flight
        check_word("status with two in flight", rd, busy_word);
        read_reg(reg_status, rd);   // first result back, newest still running
        check_word("status with one in flight", rd, busy_word);
        write_reg(reg_op_a, 32'h0F0F);
        write_reg(reg_ctrl, start_word);
        write_reg(reg_op_b, 32'hF00D);
        write_reg(reg_ctrl, start_word);
        wait_done();
        read_reg(reg_product, rd);
        check_product("product of last operands", rd, exact_product(16'h0F0F, 16'hF00D));
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin : watchdog
        #((test_cycles + margin) * clk_period);
        $display("timeout: tests did not finish within %0d cycles", test_cycles + margin);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        logic [31:0] seed_ret;
        n_checks      = 0;
        n_product_err = 0;
        n_word_err    = 0;
        n_pslverr_err = 0;
        n_other_err   = 0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed_ret = $urandom(32'hae0);
        repeat (2) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        reset_readback();
        corner_products();
        random_products();
        status_flags();
        bus_errors();
        back_to_back_starts();
        repeat (2) @(posedge clk);
        $display("checks %0d, product errors %0d, word errors %0d, pslverr errors %0d, other %0d",
                 n_checks, n_product_err, n_word_err, n_pslverr_err, n_other_err);
        if (n_product_err + n_word_err + n_pslverr_err + n_other_err == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+include
hw/mul_arith_pkg.sv
hw/mul_regmap_pkg.sv
hw/mul_core_if.sv
hw/mul_regs.sv
hw/dadda_reduce.sv
hw/kogge_stone_adder.sv
hw/mul_core.sv
hw/mul_apb_top.sv
testbench/tb_mul_apb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

if ! verilator --binary --timing -Wno-fatal -f build.f --top-module tb_mul_apb \
        -Mdir "$obj_dir" -o tb_mul_apb; then
    echo "verilator compile failed"
    exit 1
fi

if ! "./$obj_dir/tb_mul_apb" > "$log" 2>&1; then
    cat "$log"
    echo "simulation exited with an error status"
    exit 1
fi

cat "$log"

if grep -q "=== FAIL ===" "$log"; then
    exit 1
fi
exit 0
